//--- src/rob_pkg.sv
`default_nettype none

package rob_pkg;

	// ####################
	// sizes.
	// ####################

	// tag width sets the buffer depth.
	localparam int ROB_TAG_W = 3;
	localparam int ROB_DEPTH = 8;
	// count needs one more bit to tell full from empty.
	localparam int ROB_CNT_W = ROB_TAG_W + 1;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [ROB_TAG_W-1:0] rob_tag_t;
	typedef logic [ROB_CNT_W-1:0] rob_cnt_t;

	// lc3b encodings of the supported subset.
	typedef enum logic [3:0]
	{
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_not = 4'b1001
	} lc3b_opcode;

	// ####################
	// instruction word.
	// ####################

	// register form, also read by BR as nzp plus offset9.
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic mode;
		logic [1:0] unused;
		lc3b_reg sr2;
	} reg_form_t;

	// immediate form of ADD and AND.
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dr;
		lc3b_reg sr1;
		logic mode;
		logic [4:0] imm5;
	} imm_form_t;

	// same 16 bits, decoded by mode.
	typedef union packed {
		reg_form_t reg_form;
		imm_form_t imm_form;
	} lc3b_inst_u;

	// ####################
	// packets.
	// ####################

	// operands already read by the issuer.
	typedef struct packed {
		lc3b_inst_u inst;
		lc3b_word pc;
		lc3b_word sr1_val;
		lc3b_word sr2_val;
		logic [2:0] cc;
		logic predict;
	} dispatch_t;

	// dispatch packet with its rob tag.
	typedef struct packed {
		dispatch_t disp;
		rob_tag_t tag;
	} exec_req_t;

	// unit writeback, by tag.
	typedef struct packed {
		rob_tag_t tag;
		lc3b_word value;
		logic mispredict;
	} result_t;

	// retirement record.
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dest;
		lc3b_word value;
		lc3b_word pc;
		logic mispredict;
	} commit_t;

endpackage

`default_nettype wire

//--- src/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec
	import rob_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic flush,
	input logic alloc_valid,
	input exec_req_t alloc,
	output logic res_valid,
	output result_t res
);

	dispatch_t op;
	lc3b_word operand_b;
	lc3b_word alu_out;
	logic take;

	assign op = alloc.disp;

	// only ADD, AND and NOT belong here.
	assign take = alloc_valid &&
		(op.inst.reg_form.opcode == op_add ||
		op.inst.reg_form.opcode == op_and ||
		op.inst.reg_form.opcode == op_not);

	always_comb
	begin
		// mode bit set means imm5, sign extended.
		if (op.inst.reg_form.mode)
			operand_b = {{11{op.inst.imm_form.imm5[4]}}, op.inst.imm_form.imm5};
		else
			operand_b = op.sr2_val;
		case (op.inst.reg_form.opcode)
			op_add: alu_out = op.sr1_val + operand_b;
			op_and: alu_out = op.sr1_val & operand_b;
			// NOT ignores the second operand.
			default: alu_out = ~op.sr1_val;
		endcase
	end

	// strobe, dropped on flush.
	always_ff @(posedge clk)
	begin
		if (reset || flush)
			res_valid <= 1'b0;
		else
			res_valid <= take;
	end

	// result payload.
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			res.tag <= alloc.tag;
			res.value <= alu_out;
			// alu ops never mispredict.
			res.mispredict <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- src/branch_exec.sv
`timescale 1ns/1ps
`default_nettype none

module branch_exec
	import rob_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic flush,
	input logic alloc_valid,
	input exec_req_t alloc,
	output logic res_valid,
	output result_t res
);

	// stage 1 holding register.
	typedef struct packed {
		rob_tag_t tag;
		logic taken;
		logic predict;
		lc3b_word pc_seq;
		lc3b_word pc_target;
	} br_stage_t;

	dispatch_t op;
	logic take;
	logic [8:0] offset9;
	lc3b_word pc_seq;
	lc3b_word pc_target;
	logic s1_valid;
	br_stage_t s1;

	assign op = alloc.disp;
	assign take = alloc_valid && (op.inst.reg_form.opcode == op_br);

	// offset9 spans sr1, mode, unused and sr2.
	assign offset9 = {op.inst.reg_form.sr1, op.inst.reg_form.mode,
		op.inst.reg_form.unused, op.inst.reg_form.sr2};

	// both candidates. target is word aligned.
	assign pc_seq = op.pc + 16'd2;
	assign pc_target = pc_seq + {{6{offset9[8]}}, offset9, 1'b0};

	// ####################
	// stage 1.
	// ####################

	always_ff @(posedge clk)
	begin
		if (reset || flush)
			s1_valid <= 1'b0;
		else
			s1_valid <= take;
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			s1.tag <= alloc.tag;
			// dr carries the nzp mask.
			s1.taken <= |(op.inst.reg_form.dr & op.cc);
			s1.predict <= op.predict;
			s1.pc_seq <= pc_seq;
			s1.pc_target <= pc_target;
		end
	end

	// ####################
	// stage 2.
	// ####################

	always_ff @(posedge clk)
	begin
		if (reset || flush)
			res_valid <= 1'b0;
		else
			res_valid <= s1_valid;
	end

	always_ff @(posedge clk)
	begin
		if (s1_valid)
		begin
			res.tag <= s1.tag;
			// resolved next pc.
			res.value <= s1.taken ? s1.pc_target : s1.pc_seq;
			res.mispredict <= s1.taken != s1.predict;
		end
	end

endmodule

`default_nettype wire

//--- src/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
	import rob_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic dispatch_valid,
	input dispatch_t dispatch,
	output logic alloc_valid,
	output exec_req_t alloc,
	input logic alu_res_valid,
	input logic br_res_valid,
	input result_t alu_res,
	input result_t br_res,
	output logic commit_valid,
	output commit_t commit,
	output logic flush,
	output logic full,
	output logic empty
);

	// entry fields, indexed by tag.
	lc3b_opcode opcode_q [ROB_DEPTH];
	lc3b_reg dest_q [ROB_DEPTH];
	lc3b_word value_q [ROB_DEPTH];
	lc3b_word pc_q [ROB_DEPTH];
	logic mispredict_q [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] valid_q;

	// head is oldest, tail is next free.
	rob_tag_t head;
	rob_tag_t tail;
	rob_cnt_t count;

	logic accept;
	logic retire;

	assign full = (count == ROB_CNT_W'(ROB_DEPTH));
	assign empty = (count == '0);

	// no alloc during full or flush.
	assign accept = dispatch_valid && !full && !flush;
	// oldest entry done, retire it.
	assign retire = valid_q[head] && !empty && !flush;

	// ####################
	// issue to units.
	// ####################

	always_ff @(posedge clk)
	begin
		if (reset)
			alloc_valid <= 1'b0;
		else
			alloc_valid <= accept;
	end

	// tag is the slot being filled.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			alloc.disp <= dispatch;
			alloc.tag <= tail;
		end
	end

	// ####################
	// pointers and count.
	// ####################

	always_ff @(posedge clk)
	begin
		if (reset || flush)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			if (accept)
				tail <= tail + 1'b1;
			if (retire)
				head <= head + 1'b1;
			// alloc and retire together keep the count.
			case ({accept, retire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// ####################
	// entry state.
	// ####################

	always_ff @(posedge clk)
	begin
		if (reset || flush)
			valid_q <= '0;
		else
		begin
			// new entry waits for its result.
			if (accept)
				valid_q[tail] <= 1'b0;
			// two write ports, tags always differ.
			if (alu_res_valid)
				valid_q[alu_res.tag] <= 1'b1;
			if (br_res_valid)
				valid_q[br_res.tag] <= 1'b1;
			// slot freed on retire.
			if (retire)
				valid_q[head] <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			opcode_q[tail] <= dispatch.inst.reg_form.opcode;
			// nzp mask for a branch, unused.
			dest_q[tail] <= dispatch.inst.reg_form.dr;
			pc_q[tail] <= dispatch.pc;
		end
		if (alu_res_valid)
		begin
			value_q[alu_res.tag] <= alu_res.value;
			mispredict_q[alu_res.tag] <= alu_res.mispredict;
		end
		if (br_res_valid)
		begin
			value_q[br_res.tag] <= br_res.value;
			mispredict_q[br_res.tag] <= br_res.mispredict;
		end
	end

	// ####################
	// commit and flush.
	// ####################

	// flush rides along with the mispredicted commit.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			commit_valid <= 1'b0;
			flush <= 1'b0;
		end
		else
		begin
			commit_valid <= retire;
			flush <= retire && mispredict_q[head];
		end
	end

	always_ff @(posedge clk)
	begin
		if (retire)
		begin
			commit.opcode <= opcode_q[head];
			commit.dest <= dest_q[head];
			commit.value <= value_q[head];
			commit.pc <= pc_q[head];
			commit.mispredict <= mispredict_q[head];
		end
	end

endmodule

`default_nettype wire

//--- src/rob_core.sv
`timescale 1ns/1ps
`default_nettype none

module rob_core
	import rob_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic dispatch_valid,
	input dispatch_t dispatch,
	output logic commit_valid,
	output commit_t commit,
	output logic flush,
	output logic full,
	output logic empty
);

	// issue bus, shared by both units.
	logic alloc_valid;
	exec_req_t alloc;

	// result strobes into the rob.
	logic alu_res_valid;
	result_t alu_res;
	logic br_res_valid;
	result_t br_res;

	reorder_buffer u_reorder_buffer
	(
		.clk(clk),
		.reset(reset),
		.dispatch_valid(dispatch_valid),
		.dispatch(dispatch),
		.alloc_valid(alloc_valid),
		.alloc(alloc),
		.alu_res_valid(alu_res_valid),
		.br_res_valid(br_res_valid),
		.alu_res(alu_res),
		.br_res(br_res),
		.commit_valid(commit_valid),
		.commit(commit),
		.flush(flush),
		.full(full),
		.empty(empty)
	);

	// ADD, AND, NOT.
	alu_exec u_alu_exec
	(
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.alloc_valid(alloc_valid),
		.alloc(alloc),
		.res_valid(alu_res_valid),
		.res(alu_res)
	);

	// BR, two stages.
	branch_exec u_branch_exec
	(
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.alloc_valid(alloc_valid),
		.alloc(alloc),
		.res_valid(br_res_valid),
		.res(br_res)
	);

endmodule

`default_nettype wire

//--- dv/rob_core_sva.sv
`timescale 1ns/1ps
`default_nettype none

module rob_core_sva
	import rob_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic alloc_valid,
	input logic full,
	input logic flush,
	input logic empty,
	input logic commit_valid,
	input rob_cnt_t count,
	input logic alu_res_valid,
	input logic br_res_valid,
	input result_t alu_res,
	input result_t br_res
);

	// failed assertions so far.
	int fail_count = 0;

	// ####################
	// allocation.
	// ####################

	// a full or flushing cycle blocks the next issue.
	alloc_blocked: assert property (@(posedge clk) disable iff (reset)
		(full || flush) |=> !alloc_valid)
		else
		begin
			fail_count++;
			$error("alloc issued after a full or flush cycle");
		end

	// occupancy bound.
	count_bound: assert property (@(posedge clk) disable iff (reset)
		count <= ROB_DEPTH)
		else
		begin
			fail_count++;
			$error("entry count above buffer depth");
		end

	// ####################
	// flush and results.
	// ####################

	// buffer is clean right after the flush cycle.
	flush_clears: assert property (@(posedge clk) disable iff (reset)
		flush |=> (empty && !commit_valid))
		else
		begin
			fail_count++;
			$error("buffer not empty or commit seen after flush");
		end

	// the two write ports never hit one slot.
	distinct_tags: assert property (@(posedge clk) disable iff (reset)
		!(alu_res_valid && br_res_valid && alu_res.tag == br_res.tag))
		else
		begin
			fail_count++;
			$error("alu and branch results carry the same tag");
		end

endmodule

bind reorder_buffer rob_core_sva u_rob_core_sva
(
	.clk(clk),
	.reset(reset),
	.alloc_valid(alloc_valid),
	.full(full),
	.flush(flush),
	.empty(empty),
	.commit_valid(commit_valid),
	.count(count),
	.alu_res_valid(alu_res_valid),
	.br_res_valid(br_res_valid),
	.alu_res(alu_res),
	.br_res(br_res)
);

`default_nettype wire

//--- dv/rob_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rob_core_tb
	import rob_pkg::*;
();

	logic clk;
	logic reset;
	logic dispatch_valid;
	dispatch_t dispatch;
	logic commit_valid;
	commit_t commit;
	logic flush;
	logic full;
	logic empty;

	// run length, also sizes the watchdog.
	int instr_total = 400;
	int reset_cycles = 16;
	int clk_period = 4;
	int seed = 32'h3397bf2e;

	// expected retirement order.
	commit_t exp_q[$];
	lc3b_word next_pc;
	int value_errs = 0;
	int other_errs = 0;
	int commits = 0;
	int flushes = 0;

	rob_core u_rob_core
	(
		.clk(clk),
		.reset(reset),
		.dispatch_valid(dispatch_valid),
		.dispatch(dispatch),
		.commit_valid(commit_valid),
		.commit(commit),
		.flush(flush),
		.full(full),
		.empty(empty)
	);

	// 4 ns clock.
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ####################
	// stimulus helpers.
	// ####################

	function automatic int unsigned rand_below(input int unsigned n);
		logic [31:0] r;
		r = $random(seed);
		return r % n;
	endfunction

	// kind 0 mixes 60/40, 1 forces alu, 2 forces a branch.
	function automatic dispatch_t random_instr(input int kind);
		dispatch_t d;
		logic [3:0] op;
		logic [31:0] r;
		if (kind == 2 || (kind == 0 && rand_below(100) >= 60))
			op = 4'b0000;
		else
		begin
			case (rand_below(3))
				0: op = 4'b0001;
				1: op = 4'b0101;
				default: op = 4'b1001;
			endcase
		end
		// low 12 bits give form, regs, imm5 or nzp plus offset9.
		r = $random(seed);
		d.inst = {op, r[11:0]};
		d.pc = next_pc;
		r = $random(seed);
		d.sr1_val = r[15:0];
		d.sr2_val = r[31:16];
		r = $random(seed);
		d.cc = r[2:0];
		d.predict = r[3];
		return d;
	endfunction

	// ####################
	// reference model.
	// ####################

	// lc3b rules, straight from the instruction bits.
	function automatic commit_t expected_commit(input dispatch_t d);
		logic [15:0] w;
		logic [15:0] operand;
		logic [15:0] offs;
		logic taken;
		commit_t c;
		w = d.inst;
		c.opcode = lc3b_opcode'(w[15:12]);
		c.dest = w[11:9];
		c.pc = d.pc;
		c.mispredict = 1'b0;
		if (w[15:12] == 4'b0000)
		begin
			// BR, nzp in bits 11..9.
			taken = |(w[11:9] & d.cc);
			offs = {{7{w[8]}}, w[8:0]};
			c.value = taken ? d.pc + 16'd2 + (offs << 1) : d.pc + 16'd2;
			c.mispredict = (taken != d.predict);
		end
		else
		begin
			// bit 5 picks imm5.
			operand = w[5] ? {{11{w[4]}}, w[4:0]} : d.sr2_val;
			case (w[15:12])
				4'b0001: c.value = d.sr1_val + operand;
				4'b0101: c.value = d.sr1_val & operand;
				default: c.value = ~d.sr1_val;
			endcase
		end
		return c;
	endfunction

	task automatic report_value(input string field, input logic [15:0] got,
		input logic [15:0] want);
		value_errs++;
		$display("ERR %0t %s: got %h expected %h", $time, field, got, want);
	endtask

	// compare one retired entry against the model.
	task automatic check_commit();
		commit_t exp;
		logic exp_flush;
		exp_flush = 1'b0;
		if (commit_valid)
		begin
			commits++;
			assert (exp_q.size() > 0) else
			begin
				other_errs++;
				$display("a commit arrived at %0t with nothing outstanding", $time);
			end
			if (exp_q.size() > 0)
			begin
				exp = exp_q.pop_front();
				assert (commit.opcode == exp.opcode) else
					report_value("opcode", commit.opcode, exp.opcode);
				// branch dest is don't-care.
				if (exp.opcode != op_br)
				begin
					assert (commit.dest == exp.dest) else
						report_value("dest", commit.dest, exp.dest);
				end
				assert (commit.pc == exp.pc) else
					report_value("pc", commit.pc, exp.pc);
				assert (commit.value == exp.value) else
					report_value("value", commit.value, exp.value);
				assert (commit.mispredict == exp.mispredict) else
					report_value("mispredict", commit.mispredict, exp.mispredict);
				// younger work is gone, fetch restarts at the resolved pc.
				if (exp.mispredict)
				begin
					exp_flush = 1'b1;
					flushes++;
					exp_q.delete();
					next_pc = exp.value;
				end
			end
		end
		// flush only alongside a mispredicted commit.
		assert (flush == exp_flush) else
			report_value("flush", flush, exp_flush);
		// occupancy follows the model outside a flush.
		if (!flush)
		begin
			assert (empty == (exp_q.size() == 0)) else
				report_value("empty", empty, exp_q.size() == 0);
			assert (full == (exp_q.size() == ROB_DEPTH)) else
				report_value("full", full, exp_q.size() == ROB_DEPTH);
		end
	endtask

	// one cycle, then look at settled outputs.
	task automatic step();
		@(posedge clk);
		#1;
		check_commit();
	endtask

	// isolated op into an empty buffer.
	task automatic probe_latency(input int kind, input int expect_edge);
		int edges;
		int guard;
		dispatch_valid = 1'b0;
		guard = 0;
		while ((!empty || flush || commit_valid) && guard < 100)
		begin
			step();
			guard++;
		end
		assert (guard < 100) else
		begin
			other_errs++;
			$display("buffer never drained before the latency probe at %0t", $time);
		end
		dispatch = random_instr(kind);
		exp_q.push_back(expected_commit(dispatch));
		next_pc = next_pc + 16'd2;
		dispatch_valid = 1'b1;
		// edge 0 samples the dispatch.
		edges = -1;
		do
		begin
			step();
			dispatch_valid = 1'b0;
			edges++;
		end
		while (!commit_valid && edges < 20);
		assert (edges == expect_edge) else
			report_value("latency", edges, expect_edge);
	endtask

	// ####################
	// main sequence.
	// ####################

	initial
	begin
		int issued;
		int guard;
		int sva_errs;
		dispatch_t d;
		reset = 1'b1;
		dispatch_valid = 1'b0;
		dispatch = '0;
		next_pc = 16'h3000;
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;
		// idle outputs before any dispatch.
		assert (!commit_valid && !flush && !full && empty) else
		begin
			other_errs++;
			$display("outputs were not idle after reset at %0t", $time);
		end
		issued = 0;
		while (issued < instr_total)
		begin
			if (issued % 50 == 25)
			begin
				// alternate alu and branch probes.
				if ((issued / 50) % 2 == 0)
					probe_latency(1, 3);
				else
					probe_latency(2, 4);
				issued++;
			end
			else if (!full && !flush && rand_below(100) >= 15)
			begin
				d = random_instr(0);
				dispatch = d;
				dispatch_valid = 1'b1;
				exp_q.push_back(expected_commit(d));
				next_pc = next_pc + 16'd2;
				issued++;
			end
			else
				dispatch_valid = 1'b0;
			step();
		end
		dispatch_valid = 1'b0;
		// drain what is left.
		guard = 0;
		while ((!empty || flush) && guard < 200)
		begin
			step();
			guard++;
		end
		assert (guard < 200) else
		begin
			other_errs++;
			$display("buffer did not drain at the end of the run");
		end
		repeat (4) step();
		assert (exp_q.size() == 0) else
		begin
			other_errs++;
			$display("%0d expected commits never arrived", exp_q.size());
		end
		// bound checker keeps its own tally.
		sva_errs = u_rob_core.u_reorder_buffer.u_rob_core_sva.fail_count;
		$display("errors: %0d value, %0d other, %0d assertion; %0d commits, %0d flushes",
			value_errs, other_errs, sva_errs, commits, flushes);
		if (value_errs + other_errs + sva_errs == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// ten cycles per instruction plus reset.
	initial
	begin
		#((instr_total * 10 + reset_cycles) * clk_period);
		$display("the run timed out before all instructions retired");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- rob_core.f
src/rob_pkg.sv
src/alu_exec.sv
src/branch_exec.sv
src/reorder_buffer.sv
src/rob_core.sv
dv/rob_core_sva.sv
dv/rob_core_tb.sv

//--- Bender.yml
package:
  name: rob_core

sources:
  - src/rob_pkg.sv
  - src/alu_exec.sv
  - src/branch_exec.sv
  - src/reorder_buffer.sv
  - src/rob_core.sv
  - target: simulation
    files:
      - dv/rob_core_sva.sv
      - dv/rob_core_tb.sv
